/* source/dspBusPkg.sv */
package dspBusPkg;

  // Bus widths
  localparam int dataBits = 16;
  localparam int coefBits = 24;

  typedef logic [dataBits-1:0] dataWord;
  typedef logic [coefBits-1:0] coefWord;

  // Ordinary banks, the mirror bank comes on top
  localparam int bankCount = 8;

  localparam int regAddrBits = 3;
  typedef logic [regAddrBits-1:0] regAddr;

  // Register index map, 6 and 7 are unused
  localparam regAddr addrSysr    = 3'd0;
  localparam regAddr addrCkr     = 3'd1;
  localparam regAddr addrDctl    = 3'd2;
  localparam regAddr addrDovl    = 3'd3;
  localparam regAddr addrWscr    = 3'd4;
  localparam regAddr addrWscrExt = 3'd5;

  localparam dataWord sysrReset    = 16'h0010;
  localparam dataWord ckrReset     = 16'h0006;
  localparam dataWord dctlReset    = 16'h0000;
  localparam dataWord dovlReset    = 16'h0000;
  localparam dataWord wscrReset    = 16'h7fff;
  localparam dataWord wscrExtReset = 16'h00ff;

  // Implemented bits, upper bits read as zero
  localparam int dctlBits    = 15;
  localparam int dovlBits    = 12;
  localparam int wscrBits    = 15;
  localparam int wscrExtBits = 8;

  typedef struct packed {
    logic wscrExt;
    logic wscr;
    logic dovl;
    logic dctl;
    logic ckr;
    logic sysr;
  } regSel;

endpackage

/* source/busIf.sv */
`timescale 1ns/100ps

// Register select and strobes from the MMIO decoder
interface regSelIf;
  dspBusPkg::regSel sel;
  logic rdEn;
  logic wrEn;
  dspBusPkg::dataWord wrData;

  modport decoder (output sel, output rdEn, output wrEn, output wrData);
  modport regs (input sel, input rdEn, input wrEn, input wrData);
endinterface

// DMA and serial-port words that take over the write buses
interface stealIf;
  logic idmaOe;
  dspBusPkg::dataWord idmaData;
  logic spt0Oe;
  dspBusPkg::dataWord rx0;
  logic spt1Oe;
  dspBusPkg::dataWord rx1;
  logic bdmaOe;
  dspBusPkg::coefWord bdmaBuf;

  modport source (
    output idmaOe, output idmaData,
    output spt0Oe, output rx0,
    output spt1Oe, output rx1,
    output bdmaOe, output bdmaBuf
  );
  modport merge (
    input idmaOe, input idmaData,
    input spt0Oe, input rx0,
    input spt1Oe, input rx1,
    input bdmaOe, input bdmaBuf
  );
endinterface

/* source/mmioDecode.sv */
`timescale 1ns/100ps

module mmioDecode (
  input  logic              DSPCLK,
  input  logic              rst,
  input  dspBusPkg::regAddr mmioAddr,
  input  logic              mmioRd,
  input  logic              mmioWr,
  regSelIf.decoder          sel
);

  dspBusPkg::regSel decoded;
  logic hit;

  always_comb begin
    decoded = '0;
    case (mmioAddr)
      dspBusPkg::addrSysr:    decoded.sysr = 1'b1;
      dspBusPkg::addrCkr:     decoded.ckr = 1'b1;
      dspBusPkg::addrDctl:    decoded.dctl = 1'b1;
      dspBusPkg::addrDovl:    decoded.dovl = 1'b1;
      dspBusPkg::addrWscr:    decoded.wscr = 1'b1;
      dspBusPkg::addrWscrExt: decoded.wscrExt = 1'b1;
      default:                decoded = '0;
    endcase
  end

  // Unused index leaves the select empty
  assign hit = |decoded;

  assign sel.sel = decoded;
  assign sel.rdEn = mmioRd & hit;
  assign sel.wrEn = mmioWr & hit;

endmodule

/* source/sysRegs.sv */
`timescale 1ns/100ps

module sysRegs (
  input  logic               DSPCLK,
  input  logic               rst,
  regSelIf.regs              sel,
  input  dspBusPkg::dataWord periphRd,
  output dspBusPkg::dataWord regRd
);

  dspBusPkg::dataWord sysr;
  dspBusPkg::dataWord ckr;
  logic [dspBusPkg::dctlBits-1:0] dctl;
  logic [dspBusPkg::dovlBits-1:0] dovl;
  logic [dspBusPkg::wscrBits-1:0] wscr;
  logic [dspBusPkg::wscrExtBits-1:0] wscrExt;
  dspBusPkg::dataWord regWord;

  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      sysr    <= dspBusPkg::sysrReset;
      ckr     <= dspBusPkg::ckrReset;
      dctl    <= dspBusPkg::dctlReset[dspBusPkg::dctlBits-1:0];
      dovl    <= dspBusPkg::dovlReset[dspBusPkg::dovlBits-1:0];
      wscr    <= dspBusPkg::wscrReset[dspBusPkg::wscrBits-1:0];
      wscrExt <= dspBusPkg::wscrExtReset[dspBusPkg::wscrExtBits-1:0];
    end else if (sel.wrEn) begin
      if (sel.sel.sysr) begin
        sysr <= sel.wrData;
      end
      if (sel.sel.ckr) begin
        ckr <= sel.wrData;
      end
      // Only the implemented low bits are stored
      if (sel.sel.dctl) begin
        dctl <= sel.wrData[dspBusPkg::dctlBits-1:0];
      end
      if (sel.sel.dovl) begin
        dovl <= sel.wrData[dspBusPkg::dovlBits-1:0];
      end
      if (sel.sel.wscr) begin
        wscr <= sel.wrData[dspBusPkg::wscrBits-1:0];
      end
      if (sel.sel.wscrExt) begin
        wscrExt <= sel.wrData[dspBusPkg::wscrExtBits-1:0];
      end
    end
  end

  always_comb begin
    regWord = '0;
    if (sel.sel.sysr) begin
      regWord = regWord | sysr;
    end
    if (sel.sel.ckr) begin
      regWord = regWord | ckr;
    end
    if (sel.sel.dctl) begin
      regWord = regWord | dspBusPkg::dataWord'(dctl);
    end
    if (sel.sel.dovl) begin
      regWord = regWord | dspBusPkg::dataWord'(dovl);
    end
    if (sel.sel.wscr) begin
      regWord = regWord | dspBusPkg::dataWord'(wscr);
    end
    if (sel.sel.wscrExt) begin
      regWord = regWord | dspBusPkg::dataWord'(wscrExt);
    end
  end

  // Peripheral words arrive already gated by their units
  assign regRd = sel.rdEn ? (regWord | periphRd) : '0;

endmodule

/* source/dmdMerge.sv */
`timescale 1ns/100ps

module dmdMerge (
  input  logic               DSPCLK,
  input  logic               rst,
  stealIf.merge              steal,
  regSelIf.decoder           sel,
  input  dspBusPkg::dataWord unitDmd,
  input  dspBusPkg::dataWord euPmd,
  input  dspBusPkg::dataWord regRd,
  input  logic               sreq,
  input  logic               goCx,
  input  logic               pwrite,
  input  logic               redoSti,
  output dspBusPkg::dataWord dmWdBase,
  output dspBusPkg::dataWord dmWd,
  output dspBusPkg::dataWord pmWd
);

  localparam int w = dspBusPkg::dataBits;

  dspBusPkg::dataWord innerWd;
  dspBusPkg::dataWord retryWord;
  dspBusPkg::dataWord redoWord;
  dspBusPkg::dataWord pmWdBase;
  dspBusPkg::dataWord stealWord;
  logic stealOe;

  // Idle units drive zero, so a plain OR merges them
  assign innerWd = unitDmd | regRd;
  assign sel.wrData = innerWd;

  // Interrupted store, replayed later
  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      retryWord <= '0;
    end else if (sreq && goCx) begin
      retryWord <= pwrite ? euPmd : innerWd;
    end
  end

  assign redoWord = redoSti ? retryWord : '0;

  assign dmWdBase = innerWd | redoWord;
  assign pmWdBase = euPmd | redoWord;

  // DM steal words are ORed, bdma gives its low half
  assign stealOe = steal.idmaOe | steal.spt0Oe | steal.spt1Oe | steal.bdmaOe;

  assign stealWord = ({w{steal.idmaOe}} & steal.idmaData)
                   | ({w{steal.spt0Oe}} & steal.rx0)
                   | ({w{steal.spt1Oe}} & steal.rx1)
                   | ({w{steal.bdmaOe}} & steal.bdmaBuf[w-1:0]);

  assign dmWd = stealOe ? stealWord : dmWdBase;

  // PM side is a priority pick
  always_comb begin
    if (steal.idmaOe) begin
      pmWd = steal.idmaData;
    end else if (steal.bdmaOe) begin
      pmWd = steal.bdmaBuf[dspBusPkg::coefBits-1 -: w];
    end else begin
      pmWd = pmWdBase;
    end
  end

endmodule

/* source/bankReadMux.sv */
`timescale 1ns/100ps

module bankReadMux #(
  parameter type payloadT = dspBusPkg::dataWord
) (
  input  payloadT                       banks [dspBusPkg::bankCount],
  input  payloadT                       mirror,
  input  logic [dspBusPkg::bankCount-1:0] oe,
  input  logic                          mirrorOe,
  input  logic                          useMirror,
  output payloadT                       rd,
  output logic                          anyOe
);

  logic [dspBusPkg::bankCount:0] allOe;
  payloadT defaultWord;

  assign allOe = {mirrorOe, oe};
  assign anyOe = |allOe;

  assign defaultWord = useMirror ? mirror : banks[0];

  // Anything but a single select falls back to the default
  always_comb begin
    rd = defaultWord;
    if ($onehot(allOe)) begin
      if (mirrorOe) begin
        rd = mirror;
      end
      for (int i = 0; i < dspBusPkg::bankCount; i++) begin
        if (oe[i]) begin
          rd = banks[i];
        end
      end
    end
  end

endmodule

/* source/dspDataBus.sv */
`timescale 1ns/100ps

module dspDataBus (
  input  logic                           DSPCLK,
  input  logic                           rst,
  input  dspBusPkg::regAddr              mmioAddr,
  input  logic                           mmioRd,
  input  logic                           mmioWr,
  input  dspBusPkg::dataWord             periphRd,
  input  dspBusPkg::dataWord             unitDmd,
  input  dspBusPkg::dataWord             euPmd,
  input  logic                           sreq,
  input  logic                           goCx,
  input  logic                           pwrite,
  input  logic                           redoSti,
  input  logic                           idmaOe,
  input  dspBusPkg::dataWord             idmaData,
  input  logic                           spt0Oe,
  input  dspBusPkg::dataWord             rx0,
  input  logic                           spt1Oe,
  input  dspBusPkg::dataWord             rx1,
  input  logic                           bdmaOe,
  input  dspBusPkg::coefWord             bdmaBuf,
  input  logic                           emcDmdOe,
  input  dspBusPkg::dataWord             emcDmd,
  input  logic                           emcPmdOe,
  input  dspBusPkg::dataWord             emcPmd,
  input  dspBusPkg::dataWord             dmBanks [dspBusPkg::bankCount],
  input  dspBusPkg::dataWord             dmMirror,
  input  logic [dspBusPkg::bankCount-1:0] dmOe,
  input  logic                           dmMirrorOe,
  input  dspBusPkg::dataWord             pmBanks [dspBusPkg::bankCount],
  input  logic [dspBusPkg::bankCount-1:0] pmOe,
  input  dspBusPkg::coefWord             cmBanks [dspBusPkg::bankCount],
  input  dspBusPkg::coefWord             cmMirror,
  input  logic [dspBusPkg::bankCount-1:0] cmOe,
  input  logic                           cmMirrorOe,
  output dspBusPkg::dataWord             dmWd,
  output dspBusPkg::dataWord             pmWd,
  output dspBusPkg::dataWord             dmdIn,
  output dspBusPkg::dataWord             pmdIn,
  output dspBusPkg::coefWord             cmRd
);

  regSelIf regBus ();
  stealIf stealBus ();

  dspBusPkg::dataWord regRd;
  dspBusPkg::dataWord dmWdBase;
  dspBusPkg::dataWord dmRd;
  dspBusPkg::dataWord pmRd;
  logic dmAnyOe;
  logic pmAnyOe;

  assign stealBus.idmaOe = idmaOe;
  assign stealBus.idmaData = idmaData;
  assign stealBus.spt0Oe = spt0Oe;
  assign stealBus.rx0 = rx0;
  assign stealBus.spt1Oe = spt1Oe;
  assign stealBus.rx1 = rx1;
  assign stealBus.bdmaOe = bdmaOe;
  assign stealBus.bdmaBuf = bdmaBuf;

  mmioDecode uDecode (
    .DSPCLK   (DSPCLK),
    .rst      (rst),
    .mmioAddr (mmioAddr),
    .mmioRd   (mmioRd),
    .mmioWr   (mmioWr),
    .sel      (regBus)
  );

  sysRegs uRegs (
    .DSPCLK   (DSPCLK),
    .rst      (rst),
    .sel      (regBus),
    .periphRd (periphRd),
    .regRd    (regRd)
  );

  dmdMerge uMerge (
    .DSPCLK   (DSPCLK),
    .rst      (rst),
    .steal    (stealBus),
    .sel      (regBus),
    .unitDmd  (unitDmd),
    .euPmd    (euPmd),
    .regRd    (regRd),
    .sreq     (sreq),
    .goCx     (goCx),
    .pwrite   (pwrite),
    .redoSti  (redoSti),
    .dmWdBase (dmWdBase),
    .dmWd     (dmWd),
    .pmWd     (pmWd)
  );

  bankReadMux #(.payloadT(dspBusPkg::dataWord)) uDmMux (
    .banks     (dmBanks),
    .mirror    (dmMirror),
    .oe        (dmOe),
    .mirrorOe  (dmMirrorOe),
    .useMirror (1'b1),
    .rd        (dmRd),
    .anyOe     (dmAnyOe)
  );

  // PM has no mirror bank
  bankReadMux #(.payloadT(dspBusPkg::dataWord)) uPmMux (
    .banks     (pmBanks),
    .mirror    ('0),
    .oe        (pmOe),
    .mirrorOe  (1'b0),
    .useMirror (1'b0),
    .rd        (pmRd),
    .anyOe     (pmAnyOe)
  );

  bankReadMux #(.payloadT(dspBusPkg::coefWord)) uCmMux (
    .banks     (cmBanks),
    .mirror    (cmMirror),
    .oe        (cmOe),
    .mirrorOe  (cmMirrorOe),
    .useMirror (1'b1),
    .rd        (cmRd),
    .anyOe     ()
  );

  // Bank data first, then external memory, then the bus loops back
  assign dmdIn = dmAnyOe ? dmRd : (emcDmdOe ? emcDmd : dmWdBase);
  assign pmdIn = pmAnyOe ? pmRd : (emcPmdOe ? emcPmd : euPmd);

endmodule

/* verification/dspDataBus_sva.sv */
`timescale 1ns/100ps

module dspDataBusSva (
  input logic                           DSPCLK,
  input logic                           rst,
  input dspBusPkg::regAddr              mmioAddr,
  input logic                           mmioRd,
  input logic                           mmioWr,
  input dspBusPkg::dataWord             periphRd,
  input dspBusPkg::dataWord             unitDmd,
  input logic                           redoSti,
  input logic                           idmaOe,
  input dspBusPkg::dataWord             idmaData,
  input logic                           spt0Oe,
  input dspBusPkg::dataWord             rx0,
  input logic                           spt1Oe,
  input dspBusPkg::dataWord             rx1,
  input logic                           bdmaOe,
  input dspBusPkg::coefWord             bdmaBuf,
  input logic                           emcDmdOe,
  input logic                           emcPmdOe,
  input logic [dspBusPkg::bankCount-1:0] dmOe,
  input logic                           dmMirrorOe,
  input logic [dspBusPkg::bankCount-1:0] cmOe,
  input logic                           cmMirrorOe,
  input dspBusPkg::coefWord             cmMirror,
  input dspBusPkg::coefWord             cmRd,
  input dspBusPkg::dataWord             dmWd,
  input dspBusPkg::dataWord             dmdIn
);

  logic sysrWritten;

  // Set once SYSR may have left its reset value
  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      sysrWritten <= 1'b0;
    end else if (mmioWr && mmioAddr == dspBusPkg::addrSysr) begin
      sysrWritten <= 1'b1;
    end
  end

  stealOnDm: assert property (@(posedge DSPCLK) disable iff (rst)
    (idmaOe || spt0Oe || spt1Oe || bdmaOe) |->
      dmWd == ((idmaOe ? idmaData : 16'h0) | (spt0Oe ? rx0 : 16'h0)
             | (spt1Oe ? rx1 : 16'h0) | (bdmaOe ? bdmaBuf[15:0] : 16'h0)))
    else $error("dmWd is not the OR of the enabled steal words");

  cmIdleMirror: assert property (@(posedge DSPCLK) disable iff (rst)
    (cmOe == '0 && !cmMirrorOe && !emcDmdOe && !emcPmdOe) |-> cmRd == cmMirror)
    else $error("cmRd does not show the CM mirror with no bank selected");

  sysrAfterReset: assert property (@(posedge DSPCLK) disable iff (rst)
    (!sysrWritten && mmioRd && mmioAddr == dspBusPkg::addrSysr && periphRd == '0
     && unitDmd == '0 && !redoSti && dmOe == '0 && !dmMirrorOe && !emcDmdOe)
    |-> dmdIn == dspBusPkg::sysrReset)
    else $error("SYSR read after reset does not return its reset value");

endmodule

/* verification/dspDataBusTb.sv */
`timescale 1ns/100ps

module dspDataBusTb;

  // Cycles per test: reset, reads, writes, held write, steals, retry, banks, then margin
  localparam int cycleLimit = 4 + 9 + 17 + 4 + 17 + 6 + 14 + 32;

  logic DSPCLK, rst, mmioRd, mmioWr, sreq, goCx, pwrite, redoSti;
  logic idmaOe, spt0Oe, spt1Oe, bdmaOe, emcDmdOe, emcPmdOe, dmMirrorOe, cmMirrorOe;
  dspBusPkg::regAddr mmioAddr;
  dspBusPkg::dataWord periphRd, unitDmd, euPmd, idmaData, rx0, rx1, emcDmd, emcPmd;
  dspBusPkg::dataWord dmMirror, dmWd, pmWd, dmdIn, pmdIn;
  dspBusPkg::coefWord bdmaBuf, cmMirror, cmRd;
  dspBusPkg::dataWord dmBanks [dspBusPkg::bankCount];
  dspBusPkg::dataWord pmBanks [dspBusPkg::bankCount];
  dspBusPkg::coefWord cmBanks [dspBusPkg::bankCount];
  logic [dspBusPkg::bankCount-1:0] dmOe, pmOe, cmOe;
  logic [31:0] lfsrState = 32'he3037a27;
  int errorCount = 0;
  int checkCount = 0;
  int cycleCount = 0;

  dspDataBus dut (.*);

  bind dspDataBus dspDataBusSva sva (.*);

  always #5 DSPCLK = ~DSPCLK;

  always @(posedge DSPCLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout after %0d cycles, the tests did not complete", cycleCount);
      $display("Finished with errors");
      $finish;
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], fb};
    return fb;
  endfunction

  function automatic dspBusPkg::dataWord randomWord();
    dspBusPkg::dataWord w;
    for (int i = 0; i < 16; i++) w = {w[14:0], lfsrBit()};
    return w;
  endfunction

  function automatic dspBusPkg::coefWord randomCoef();
    dspBusPkg::coefWord w;
    for (int i = 0; i < 24; i++) w = {w[22:0], lfsrBit()};
    return w;
  endfunction

  function automatic dspBusPkg::dataWord resetValueOf(int a);
    case (a)
      0: return dspBusPkg::sysrReset;
      1: return dspBusPkg::ckrReset;
      2: return dspBusPkg::dctlReset;
      3: return dspBusPkg::dovlReset;
      4: return dspBusPkg::wscrReset;
      5: return dspBusPkg::wscrExtReset;
      default: return 16'h0;
    endcase
  endfunction

  function automatic dspBusPkg::dataWord regMaskOf(int a);
    case (a)
      0, 1: return 16'hffff;
      2: return dspBusPkg::dataWord'((32'd1 << dspBusPkg::dctlBits) - 1);
      3: return dspBusPkg::dataWord'((32'd1 << dspBusPkg::dovlBits) - 1);
      4: return dspBusPkg::dataWord'((32'd1 << dspBusPkg::wscrBits) - 1);
      5: return dspBusPkg::dataWord'((32'd1 << dspBusPkg::wscrExtBits) - 1);
      default: return 16'h0;
    endcase
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic nextCycle();
    @(posedge DSPCLK);
    #1;
  endtask

  task automatic settle();
    #3;
  endtask

  task automatic clearInputs();
    {rst, mmioRd, mmioWr, sreq, goCx, pwrite, redoSti} = '0;
    {idmaOe, spt0Oe, spt1Oe, bdmaOe, emcDmdOe, emcPmdOe, dmMirrorOe, cmMirrorOe} = '0;
    mmioAddr = '0;
    {periphRd, unitDmd, euPmd, idmaData, rx0, rx1, emcDmd, emcPmd, dmMirror} = '0;
    {bdmaBuf, cmMirror, dmOe, pmOe, cmOe} = '0;
    for (int i = 0; i < dspBusPkg::bankCount; i++) begin
      dmBanks[i] = '0;
      pmBanks[i] = '0;
      cmBanks[i] = '0;
    end
  endtask

  task automatic readResetValues();
    for (int a = 0; a < 8; a++) begin
      nextCycle();
      mmioAddr = dspBusPkg::regAddr'(a);
      mmioRd = 1'b1;
      settle();
      checkValue("dmdIn", dmdIn, resetValueOf(a) & regMaskOf(a));
    end
    nextCycle();
    mmioRd = 1'b0;
  endtask

  task automatic writeAndReadRegs();
    dspBusPkg::dataWord word;
    dspBusPkg::dataWord periph;
    for (int a = 0; a < 8; a++) begin
      word = randomWord();
      periph = randomWord();
      nextCycle();
      mmioAddr = dspBusPkg::regAddr'(a);
      {mmioWr, mmioRd} = 2'b10;
      unitDmd = word;
      periphRd = '0;
      nextCycle();
      {mmioWr, unitDmd} = '0;
      mmioRd = 1'b1;
      periphRd = periph;
      settle();
      // Unused indices drop the write and the peripheral word
      checkValue("dmdIn", dmdIn, (a < 6) ? ((word & regMaskOf(a)) | periph) : 32'h0);
    end
    nextCycle();
    mmioRd = 1'b0;
    periphRd = '0;
  endtask

  task automatic writeHeldStrobe();
    dspBusPkg::dataWord first;
    dspBusPkg::dataWord second;
    first = randomWord();
    second = randomWord();
    nextCycle();
    mmioAddr = dspBusPkg::addrDovl;
    mmioWr = 1'b1;
    unitDmd = first;
    nextCycle();
    unitDmd = second;
    nextCycle();
    {mmioWr, unitDmd} = '0;
    mmioRd = 1'b1;
    settle();
    // A held strobe writes at every edge, so the last word stays
    checkValue("dmdIn", dmdIn, second & regMaskOf(dspBusPkg::addrDovl));
    nextCycle();
    mmioRd = 1'b0;
  endtask

  task automatic stealBuses();
    dspBusPkg::dataWord dmExp;
    dspBusPkg::dataWord pmExp;
    for (int m = 0; m < 16; m++) begin
      nextCycle();
      {unitDmd, euPmd, idmaData, rx0, rx1} = {randomWord(), randomWord(), randomWord(),
                                              randomWord(), randomWord()};
      bdmaBuf = randomCoef();
      {bdmaOe, spt1Oe, spt0Oe, idmaOe} = 4'(m);
      settle();
      dmExp = (m == 0) ? unitDmd : 16'h0;
      if (idmaOe) dmExp = dmExp | idmaData;
      if (spt0Oe) dmExp = dmExp | rx0;
      if (spt1Oe) dmExp = dmExp | rx1;
      if (bdmaOe) dmExp = dmExp | bdmaBuf[15:0];
      pmExp = idmaOe ? idmaData : (bdmaOe ? bdmaBuf[23:8] : euPmd);
      checkValue("dmWd", dmWd, dmExp);
      checkValue("pmWd", pmWd, pmExp);
    end
    nextCycle();
    {bdmaOe, spt1Oe, spt0Oe, idmaOe} = '0;
  endtask

  task automatic replayStore();
    dspBusPkg::dataWord latched;
    for (int p = 1; p >= 0; p--) begin
      nextCycle();
      unitDmd = randomWord();
      euPmd = randomWord();
      {sreq, goCx, pwrite} = {2'b11, p == 1};
      latched = pwrite ? euPmd : unitDmd;
      nextCycle();
      {sreq, goCx, redoSti} = 3'b001;
      unitDmd = randomWord();
      euPmd = randomWord();
      settle();
      checkValue("dmWd", dmWd, unitDmd | latched);
      checkValue("pmWd", pmWd, euPmd | latched);
      nextCycle();
      redoSti = 1'b0;
      settle();
      checkValue("dmWd", dmWd, unitDmd);
      checkValue("pmWd", pmWd, euPmd);
    end
  endtask

  task automatic readBanks();
    nextCycle();
    for (int i = 0; i < dspBusPkg::bankCount; i++) begin
      dmBanks[i] = randomWord();
      pmBanks[i] = randomWord();
      cmBanks[i] = randomCoef();
    end
    {dmMirror, emcDmd, emcPmd, unitDmd, euPmd} = {randomWord(), randomWord(),
                                                 randomWord(), randomWord(), randomWord()};
    cmMirror = randomCoef();
    for (int i = 0; i < dspBusPkg::bankCount; i++) begin
      nextCycle();
      {dmOe, pmOe, cmOe} = {3{8'(1 << i)}};
      settle();
      checkValue("dmdIn", dmdIn, dmBanks[i]);
      checkValue("pmdIn", pmdIn, pmBanks[i]);
      checkValue("cmRd", cmRd, cmBanks[i]);
    end
    nextCycle();
    {dmOe, pmOe, cmOe} = '0;
    {emcDmdOe, emcPmdOe} = 2'b11;
    settle();
    checkValue("dmdIn", dmdIn, emcDmd);
    checkValue("pmdIn", pmdIn, emcPmd);
    checkValue("cmRd", cmRd, cmMirror);
    nextCycle();
    {emcDmdOe, emcPmdOe} = 2'b00;
    settle();
    checkValue("dmdIn", dmdIn, unitDmd);
    checkValue("pmdIn", pmdIn, euPmd);
    nextCycle();
    {dmMirrorOe, cmMirrorOe} = 2'b11;
    settle();
    checkValue("dmdIn", dmdIn, dmMirror);
    checkValue("cmRd", cmRd, cmMirror);
    // Two-hot select falls back to the default even with emc on
    nextCycle();
    {dmMirrorOe, cmMirrorOe, emcDmdOe, emcPmdOe} = 4'b0011;
    {dmOe, pmOe, cmOe} = {3{8'h06}};
    settle();
    checkValue("dmdIn", dmdIn, dmMirror);
    checkValue("pmdIn", pmdIn, pmBanks[0]);
    checkValue("cmRd", cmRd, cmMirror);
    nextCycle();
    clearInputs();
  endtask

  initial begin
    DSPCLK = 1'b0;
    clearInputs();
    rst = 1'b1;
    repeat (4) @(posedge DSPCLK);
    #1;
    rst = 1'b0;
    readResetValues();
    writeAndReadRegs();
    writeHeldStrobe();
    stealBuses();
    replayStore();
    readBanks();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* filelist.f */
source/dspBusPkg.sv
source/busIf.sv
source/mmioDecode.sv
source/sysRegs.sv
source/dmdMerge.sv
source/bankReadMux.sv
source/dspDataBus.sv
verification/dspDataBus_sva.sv
verification/dspDataBusTb.sv
